//--- verilog/p_hit_pkg.sv
`default_nettype none

package p_hit_pkg;

    localparam int D_BITS     = 32;
    localparam int Q_BITS     = 16;
    localparam int ID_BITS    = 16;
    localparam int FIFO_DEPTH = 16;

    // Q16.16 coordinate
    typedef logic signed [D_BITS-1:0] coord_t;
    typedef logic [ID_BITS-1:0] id_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    // input record of the t path
    typedef struct packed {
        vec3_t normal;
        vec3_t v0;
        vec3_t origin;
        vec3_t dir;
    } ray_tri_t;

    // carried alongside for the inside-triangle stage
    typedef struct packed {
        vec3_t v0;
        vec3_t v1;
        vec3_t v2;
        vec3_t normal;
        id_t   id;
    } tri_side_t;

    typedef enum logic [1:0] {
        IDLE,
        DOT,
        DIVIDE,
        DONE
    } div_state_t;

    // full product, arithmetic shift by Q_BITS, wrap to D_BITS
    function automatic coord_t q_mul(input coord_t a, input coord_t b);
        logic signed [2*D_BITS-1:0] p;
        p = a * b;
        return p[Q_BITS+D_BITS-1:Q_BITS];
    endfunction

endpackage

`default_nettype wire

//--- verilog/fifo_array.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_array #(
    parameter int WIDTH = 32
) (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    logic [WIDTH-1:0] mem [p_hit_pkg::FIFO_DEPTH];
    logic [$clog2(p_hit_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(p_hit_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(p_hit_pkg::FIFO_DEPTH):0] count;
    logic push;
    logic pop;

    assign push  = wr_en && !full;
    assign pop   = rd_en && !empty;
    assign full  = count == ($bits(count))'(p_hit_pkg::FIFO_DEPTH);
    assign empty = count == '0;
    // head entry, valid whenever not empty
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    wr_full_a: assert property (@(posedge clock) disable iff (!arst_n) !(wr_en && full))
        else $error("fifo_array: write while full");

    rd_empty_a: assert property (@(posedge clock) disable iff (!arst_n) !(rd_en && empty))
        else $error("fifo_array: read while empty");

endmodule

`default_nettype wire

//--- verilog/p_hit_1.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit_1 (
    input  logic                 clock,
    input  logic                 arst_n,
    input  p_hit_pkg::ray_tri_t  in_rec,
    input  logic                 in_wr_en,
    output logic                 in_full,
    output p_hit_pkg::coord_t    t,
    input  logic                 out_rd_en,
    output logic                 out_empty
);

    p_hit_pkg::ray_tri_t    fifo_dout;
    logic                   fifo_empty;
    logic                   fifo_rd;
    p_hit_pkg::div_state_t  state;
    p_hit_pkg::ray_tri_t    rec_q;
    p_hit_pkg::coord_t      num;
    p_hit_pkg::coord_t      den;
    logic [p_hit_pkg::D_BITS-1:0] num_mag;
    logic [p_hit_pkg::D_BITS-1:0] den_mag;
    logic [p_hit_pkg::D_BITS+p_hit_pkg::Q_BITS-1:0] quo;
    logic [p_hit_pkg::D_BITS+p_hit_pkg::Q_BITS-1:0] quo_nx;
    logic [p_hit_pkg::D_BITS-1:0] rem;
    logic [p_hit_pkg::D_BITS-1:0] rem_nx;
    logic [p_hit_pkg::D_BITS-1:0] dvs;
    logic [p_hit_pkg::D_BITS:0]   trial;
    logic [p_hit_pkg::D_BITS:0]   diff;
    logic                   ge;
    logic                   neg;
    logic                   den_zero;
    logic [$clog2(p_hit_pkg::D_BITS+p_hit_pkg::Q_BITS)-1:0] cnt;
    logic                   last_step;
    p_hit_pkg::coord_t      q_lo;
    p_hit_pkg::coord_t      t_q;

    fifo_array #(
        .WIDTH      ($bits(p_hit_pkg::ray_tri_t))
    ) rec_fifo (
        .clock      (clock),
        .arst_n     (arst_n),
        .wr_en      (in_wr_en),
        .din        (in_rec),
        .full       (in_full),
        .rd_en      (fifo_rd),
        .dout       (fifo_dout),
        .empty      (fifo_empty)
    );

    assign fifo_rd = (state == p_hit_pkg::IDLE) && !fifo_empty;

    always_comb begin
        // n . (v0 - origin) and n . dir
        num = p_hit_pkg::q_mul(rec_q.normal.x, rec_q.v0.x - rec_q.origin.x)
            + p_hit_pkg::q_mul(rec_q.normal.y, rec_q.v0.y - rec_q.origin.y)
            + p_hit_pkg::q_mul(rec_q.normal.z, rec_q.v0.z - rec_q.origin.z);
        den = p_hit_pkg::q_mul(rec_q.normal.x, rec_q.dir.x)
            + p_hit_pkg::q_mul(rec_q.normal.y, rec_q.dir.y)
            + p_hit_pkg::q_mul(rec_q.normal.z, rec_q.dir.z);
        num_mag = num[p_hit_pkg::D_BITS-1] ? -num : num;
        den_mag = den[p_hit_pkg::D_BITS-1] ? -den : den;

        // one restoring step per cycle
        trial  = {rem, quo[p_hit_pkg::D_BITS+p_hit_pkg::Q_BITS-1]};
        diff   = trial - {1'b0, dvs};
        ge     = trial >= {1'b0, dvs};
        rem_nx = ge ? diff[p_hit_pkg::D_BITS-1:0] : trial[p_hit_pkg::D_BITS-1:0];
        quo_nx = {quo[p_hit_pkg::D_BITS+p_hit_pkg::Q_BITS-2:0], ge};
        q_lo   = quo_nx[p_hit_pkg::D_BITS-1:0];
    end

    assign last_step = cnt == ($bits(cnt))'(p_hit_pkg::D_BITS + p_hit_pkg::Q_BITS - 1);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= p_hit_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                p_hit_pkg::IDLE: begin
                    if (!fifo_empty) begin
                        state <= p_hit_pkg::DOT;
                    end
                end
                p_hit_pkg::DOT: begin
                    state <= p_hit_pkg::DIVIDE;
                    cnt   <= '0;
                end
                p_hit_pkg::DIVIDE: begin
                    cnt <= cnt + 1'b1;
                    if (last_step) begin
                        state <= p_hit_pkg::DONE;
                    end
                end
                p_hit_pkg::DONE: begin
                    if (out_rd_en) begin
                        state <= p_hit_pkg::IDLE;
                    end
                end
                default: state <= p_hit_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fifo_rd) begin
            rec_q <= fifo_dout;
        end
        if (state == p_hit_pkg::DOT) begin
            quo      <= {num_mag, {p_hit_pkg::Q_BITS{1'b0}}};
            rem      <= '0;
            dvs      <= den_mag;
            neg      <= num[p_hit_pkg::D_BITS-1] ^ den[p_hit_pkg::D_BITS-1];
            den_zero <= den == '0;
        end
        if (state == p_hit_pkg::DIVIDE) begin
            quo <= quo_nx;
            rem <= rem_nx;
            // parallel ray lands on the origin
            if (last_step) begin
                t_q <= den_zero ? '0 : (neg ? -q_lo : q_lo);
            end
        end
    end

    assign t         = t_q;
    assign out_empty = state != p_hit_pkg::DONE;

    t_hold_a: assert property (@(posedge clock) disable iff (!arst_n)
        !out_empty && !out_rd_en |=> !out_empty && $stable(t))
        else $error("p_hit_1: t changed before it was read");

endmodule

`default_nettype wire

//--- verilog/scale.sv
`timescale 1ns/1ps
`default_nettype none

module scale (
    input  logic               clock,
    input  logic               arst_n,
    input  p_hit_pkg::vec3_t   x,
    input  p_hit_pkg::coord_t  a,
    input  logic               in_empty,
    output logic               in_rd_en,
    output p_hit_pkg::vec3_t   out,
    output logic               out_empty,
    input  logic               out_rd_en
);

    logic             valid;
    p_hit_pkg::vec3_t out_q;

    // take a new input when the slot is free or being drained
    assign in_rd_en = !in_empty && (!valid || out_rd_en);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (in_rd_en) begin
            valid <= 1'b1;
        end else if (out_rd_en) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            out_q.x <= p_hit_pkg::q_mul(x.x, a);
            out_q.y <= p_hit_pkg::q_mul(x.y, a);
            out_q.z <= p_hit_pkg::q_mul(x.z, a);
        end
    end

    assign out       = out_q;
    assign out_empty = !valid;

endmodule

`default_nettype wire

//--- verilog/add.sv
`timescale 1ns/1ps
`default_nettype none

module add (
    input  logic              clock,
    input  logic              arst_n,
    input  p_hit_pkg::vec3_t  x,
    input  p_hit_pkg::vec3_t  y,
    input  logic              in_empty,
    output logic              in_rd_en,
    output p_hit_pkg::vec3_t  out,
    output logic              out_empty,
    input  logic              out_rd_en
);

    logic             valid;
    p_hit_pkg::vec3_t out_q;

    assign in_rd_en = !in_empty && (!valid || out_rd_en);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (in_rd_en) begin
            valid <= 1'b1;
        end else if (out_rd_en) begin
            valid <= 1'b0;
        end
    end

    // sums wrap
    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            out_q.x <= x.x + y.x;
            out_q.y <= x.y + y.y;
            out_q.z <= x.z + y.z;
        end
    end

    assign out       = out_q;
    assign out_empty = !valid;

endmodule

`default_nettype wire

//--- verilog/p_hit_mult.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit_mult (
    input  logic                 clock,
    input  logic                 arst_n,
    input  p_hit_pkg::ray_tri_t  in_rec,
    input  logic                 in_wr_en,
    output logic                 in_full,
    output p_hit_pkg::vec3_t     out,
    input  logic                 out_rd_en,
    output logic                 out_empty
);

    p_hit_pkg::coord_t t;
    p_hit_pkg::vec3_t  dir_out;
    logic              t_full;
    logic              dir_full;
    logic              t_empty;
    logic              dir_empty;
    logic              join_empty;
    logic              rd_en;

    p_hit_1 u_p_hit_1 (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_rec     (in_rec),
        .in_wr_en   (in_wr_en),
        .in_full    (t_full),
        .t          (t),
        .out_rd_en  (rd_en),
        .out_empty  (t_empty)
    );

    // dir waits here until its own t comes out of the divider
    fifo_array #(
        .WIDTH      ($bits(p_hit_pkg::vec3_t))
    ) dir_fifo (
        .clock      (clock),
        .arst_n     (arst_n),
        .wr_en      (in_wr_en),
        .din        (in_rec.dir),
        .full       (dir_full),
        .rd_en      (rd_en),
        .dout       (dir_out),
        .empty      (dir_empty)
    );

    scale u_scale (
        .clock      (clock),
        .arst_n     (arst_n),
        .x          (dir_out),
        .a          (t),
        .in_empty   (join_empty),
        .in_rd_en   (rd_en),
        .out        (out),
        .out_empty  (out_empty),
        .out_rd_en  (out_rd_en)
    );

    assign join_empty = t_empty || dir_empty;
    assign in_full    = t_full || dir_full;

endmodule

`default_nettype wire

//--- verilog/p_hit_module.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit_module (
    input  logic                 clock,
    input  logic                 arst_n,
    input  p_hit_pkg::ray_tri_t  in_rec,
    input  logic                 in_wr_en,
    output logic                 in_full,
    output p_hit_pkg::vec3_t     out,
    input  logic                 out_rd_en,
    output logic                 out_empty
);

    p_hit_pkg::vec3_t mult_out;
    p_hit_pkg::vec3_t origin_out;
    logic             mult_full;
    logic             origin_full;
    logic             mult_empty;
    logic             origin_empty;
    logic             join_empty;
    logic             rd_en;

    p_hit_mult u_p_hit_mult (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_rec     (in_rec),
        .in_wr_en   (in_wr_en),
        .in_full    (mult_full),
        .out        (mult_out),
        .out_rd_en  (rd_en),
        .out_empty  (mult_empty)
    );

    fifo_array #(
        .WIDTH      ($bits(p_hit_pkg::vec3_t))
    ) origin_fifo (
        .clock      (clock),
        .arst_n     (arst_n),
        .wr_en      (in_wr_en),
        .din        (in_rec.origin),
        .full       (origin_full),
        .rd_en      (rd_en),
        .dout       (origin_out),
        .empty      (origin_empty)
    );

    // origin + dir * t
    add u_add (
        .clock      (clock),
        .arst_n     (arst_n),
        .x          (origin_out),
        .y          (mult_out),
        .in_empty   (join_empty),
        .in_rd_en   (rd_en),
        .out        (out),
        .out_empty  (out_empty),
        .out_rd_en  (out_rd_en)
    );

    assign join_empty = mult_empty || origin_empty;
    assign in_full    = mult_full || origin_full;

endmodule

`default_nettype wire

//--- verilog/p_hit.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit (
    input  logic                  clock,
    input  logic                  arst_n,
    input  p_hit_pkg::ray_tri_t   in_rec,
    input  p_hit_pkg::tri_side_t  in_side,
    input  logic                  in_wr_en,
    output logic                  in_full,
    output p_hit_pkg::vec3_t      hit,
    output p_hit_pkg::tri_side_t  out_side,
    input  logic                  out_rd_en,
    output logic                  out_empty
);

    logic hit_full;
    logic side_full;
    logic hit_empty;
    logic side_empty;
    logic pop;

    p_hit_module u_p_hit_module (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_rec     (in_rec),
        .in_wr_en   (in_wr_en),
        .in_full    (hit_full),
        .out        (hit),
        .out_rd_en  (pop),
        .out_empty  (hit_empty)
    );

    // vertices, normal and id ride along in order
    fifo_array #(
        .WIDTH      ($bits(p_hit_pkg::tri_side_t))
    ) side_fifo (
        .clock      (clock),
        .arst_n     (arst_n),
        .wr_en      (in_wr_en),
        .din        (in_side),
        .full       (side_full),
        .rd_en      (pop),
        .dout       (out_side),
        .empty      (side_empty)
    );

    assign in_full   = hit_full || side_full;
    assign out_empty = hit_empty || side_empty;
    // both paths leave together, only when both hold a result
    assign pop       = out_rd_en && !out_empty;

endmodule

`default_nettype wire

//--- bench/p_hit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit_tb;

    localparam int N_RECORDS  = 300;
    localparam int TIMEOUT    = 2000;
    localparam int SEED       = 41019;
    localparam int CLK_PERIOD = 10;

    logic                  clock;
    logic                  arst_n;
    p_hit_pkg::ray_tri_t   in_rec;
    p_hit_pkg::tri_side_t  in_side;
    logic                  in_wr_en;
    logic                  in_full;
    p_hit_pkg::vec3_t      hit;
    p_hit_pkg::tri_side_t  out_side;
    logic                  out_rd_en;
    logic                  out_empty;

    // expected results, oldest first
    p_hit_pkg::vec3_t      exp_hit[$];
    p_hit_pkg::tri_side_t  exp_side[$];

    int value_errors;
    int timeout_errors;
    int other_errors;
    bit drain_en;

    p_hit uut (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_rec     (in_rec),
        .in_side    (in_side),
        .in_wr_en   (in_wr_en),
        .in_full    (in_full),
        .hit        (hit),
        .out_side   (out_side),
        .out_rd_en  (out_rd_en),
        .out_empty  (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    // Q16.16 product, arithmetic shift, wrapped to 32 bits
    function automatic p_hit_pkg::coord_t fx_mul(input p_hit_pkg::coord_t a,
                                                 input p_hit_pkg::coord_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return p_hit_pkg::coord_t'(p >>> p_hit_pkg::Q_BITS);
    endfunction

    function automatic p_hit_pkg::coord_t fx_dot(input p_hit_pkg::vec3_t a,
                                                 input p_hit_pkg::vec3_t b);
        return fx_mul(a.x, b.x) + fx_mul(a.y, b.y) + fx_mul(a.z, b.z);
    endfunction

    // truncates toward zero, zero denominator gives zero
    function automatic p_hit_pkg::coord_t fx_div(input p_hit_pkg::coord_t num,
                                                 input p_hit_pkg::coord_t den);
        longint q;
        if (den == '0) begin
            q = 0;
        end else begin
            q = (longint'(num) <<< p_hit_pkg::Q_BITS) / longint'(den);
        end
        return p_hit_pkg::coord_t'(q);
    endfunction

    function automatic p_hit_pkg::vec3_t vec_sub(input p_hit_pkg::vec3_t a,
                                                 input p_hit_pkg::vec3_t b);
        p_hit_pkg::vec3_t r;
        r.x = a.x - b.x;
        r.y = a.y - b.y;
        r.z = a.z - b.z;
        return r;
    endfunction

    function automatic p_hit_pkg::vec3_t vec_add(input p_hit_pkg::vec3_t a,
                                                 input p_hit_pkg::vec3_t b);
        p_hit_pkg::vec3_t r;
        r.x = a.x + b.x;
        r.y = a.y + b.y;
        r.z = a.z + b.z;
        return r;
    endfunction

    function automatic p_hit_pkg::vec3_t vec_scale(input p_hit_pkg::vec3_t a,
                                                   input p_hit_pkg::coord_t s);
        p_hit_pkg::vec3_t r;
        r.x = fx_mul(a.x, s);
        r.y = fx_mul(a.y, s);
        r.z = fx_mul(a.z, s);
        return r;
    endfunction

    function automatic p_hit_pkg::vec3_t hit_point(input p_hit_pkg::ray_tri_t r);
        p_hit_pkg::coord_t t;
        t = fx_div(fx_dot(r.normal, vec_sub(r.v0, r.origin)), fx_dot(r.normal, r.dir));
        return vec_add(r.origin, vec_scale(r.dir, t));
    endfunction

    // uniform in +-64.0
    function automatic p_hit_pkg::coord_t rand_coord();
        return p_hit_pkg::coord_t'($urandom_range(32'h0080_0000, 0)) - 32'sh0040_0000;
    endfunction

    function automatic p_hit_pkg::vec3_t rand_vec();
        p_hit_pkg::vec3_t r;
        r.x = rand_coord();
        r.y = rand_coord();
        r.z = rand_coord();
        return r;
    endfunction

    task automatic compare_vec(input string name, input p_hit_pkg::vec3_t expected,
                               input p_hit_pkg::vec3_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail at %0t: %s expected %h_%h_%h got %h_%h_%h", $time, name,
                     expected.x, expected.y, expected.z, actual.x, actual.y, actual.z);
        end
    endtask

    task automatic compare_id(input string name, input p_hit_pkg::id_t expected,
                              input p_hit_pkg::id_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // called 1 ns after the edge, outputs are settled here
    task automatic take_output();
        p_hit_pkg::vec3_t     e_hit;
        p_hit_pkg::tri_side_t e_side;
        out_rd_en = 1'b0;
        if (!out_empty) begin
            if (exp_hit.size() == 0) begin
                other_errors++;
                $display("Error at %0t: an output appeared with no record pending", $time);
                out_rd_en = 1'b1;
            end else if (drain_en && $urandom_range(3, 0) != 0) begin
                e_hit  = exp_hit.pop_front();
                e_side = exp_side.pop_front();
                compare_vec("hit", e_hit, hit);
                compare_vec("out_side.v0", e_side.v0, out_side.v0);
                compare_vec("out_side.v1", e_side.v1, out_side.v1);
                compare_vec("out_side.v2", e_side.v2, out_side.v2);
                compare_vec("out_side.normal", e_side.normal, out_side.normal);
                compare_id("out_side.id", e_side.id, out_side.id);
                out_rd_en = 1'b1;
            end
        end
    endtask

    task automatic tick();
        @(posedge clock);
        #1;
        in_wr_en = 1'b0;
        take_output();
    endtask

    task automatic drive_record(input bit parallel);
        p_hit_pkg::ray_tri_t  rec;
        p_hit_pkg::tri_side_t side;
        rec.normal = rand_vec();
        rec.v0     = rand_vec();
        rec.origin = rand_vec();
        rec.dir    = rand_vec();
        if (parallel) begin
            // dir in the xy plane, normal along z
            rec.dir.z    = '0;
            rec.normal.x = '0;
            rec.normal.y = '0;
        end
        side.v0     = rec.v0;
        side.v1     = rand_vec();
        side.v2     = rand_vec();
        side.normal = rec.normal;
        side.id     = p_hit_pkg::id_t'($urandom_range(32'h0000_ffff, 0));
        exp_hit.push_back(parallel ? rec.origin : hit_point(rec));
        exp_side.push_back(side);
        in_rec   = rec;
        in_side  = side;
        in_wr_en = 1'b1;
    endtask

    task automatic write_record(input bit parallel);
        int cycles;
        cycles = 0;
        while (in_full && cycles < TIMEOUT) begin
            tick();
            cycles++;
        end
        if (in_full) begin
            timeout_errors++;
            $display("Timeout at %0t: in_full stayed high, record not written", $time);
        end else begin
            drive_record(parallel);
            tick();
        end
    endtask

    // timeout counts cycles without progress
    task automatic wait_drain();
        int idle;
        int last_size;
        idle = 0;
        while (exp_hit.size() > 0 && idle < TIMEOUT) begin
            last_size = exp_hit.size();
            tick();
            if (exp_hit.size() < last_size) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (exp_hit.size() > 0) begin
            timeout_errors++;
            $display("Timeout at %0t: %0d results never came out", $time, exp_hit.size());
        end
    endtask

    initial begin
        int seed_val;
        int accepted;
        int cycles;
        arst_n         = 1'b0;
        in_rec         = '0;
        in_side        = '0;
        in_wr_en       = 1'b0;
        out_rd_en      = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        drain_en       = 1'b0;
        seed_val       = $urandom(SEED);

        repeat (16) @(posedge clock);
        #1;
        arst_n = 1'b1;
        compare_flag("out_empty", 1'b1, out_empty);
        compare_flag("in_full", 1'b0, in_full);

        // random traffic, about one in eight rays parallel
        drain_en = 1'b1;
        for (int i = 0; i < N_RECORDS; i++) begin
            write_record($urandom_range(7, 0) == 0);
            repeat ($urandom_range(3, 0)) tick();
        end
        wait_drain();

        // back-pressure, fill until in_full
        drain_en    = 1'b0;
        accepted    = 0;
        cycles      = 0;
        while (!in_full && cycles < TIMEOUT) begin
            drive_record(1'b0);
            accepted++;
            tick();
            cycles++;
        end
        if (!in_full) begin
            timeout_errors++;
            $display("Timeout at %0t: in_full never rose with out_rd_en low", $time);
        end else if (accepted != p_hit_pkg::FIFO_DEPTH) begin
            // nothing leaves the side FIFO while out_rd_en is low
            other_errors++;
            $display("Error at %0t: in_full rose after %0d records instead of %0d", $time,
                     accepted, p_hit_pkg::FIFO_DEPTH);
        end
        repeat (100) tick();
        drain_en = 1'b1;
        wait_drain();
        // extra outputs would be caught by take_output
        repeat (100) tick();

        $display("errors: %0d value, %0d timeout, %0d other", value_errors, timeout_errors,
                 other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- p_hit.f
verilog/p_hit_pkg.sv
verilog/fifo_array.sv
verilog/p_hit_1.sv
verilog/scale.sv
verilog/add.sv
verilog/p_hit_mult.sv
verilog/p_hit_module.sv
verilog/p_hit.sv
bench/p_hit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= p_hit_tb
FILELIST   ?= p_hit.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= TEST FAILED
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
